//--- source/ahb_sram_pkg.sv
package ahb_sram_pkg;

	// Bus widths
	localparam int w_data  = 32;          // AHB data bus
	localparam int w_addr  = 32;          // AHB address bus
	localparam int w_bytes = w_data / 8;  // Byte lanes per word

	// Memory sizes in words
	localparam int depth0 = 2048;  // SRAM 0
	localparam int depth1 = 512;   // SRAM 1

	// Memory map, a region is selected on the upper 16 address bits
	localparam logic [w_addr-1:0] base0       = 32'h0000_0000;  // SRAM 0 base
	localparam logic [w_addr-1:0] base1       = 32'h0001_0000;  // SRAM 1 base
	localparam logic [w_addr-1:0] region_mask = 32'hffff_0000;  // Region compare bits

	// AHB transfer type
	typedef enum logic [1:0] {
		trans_idle   = 2'b00,  // No transfer
		trans_busy   = 2'b01,  // Master inserts a pause in a burst
		trans_nonseq = 2'b10,  // Single or first transfer
		trans_seq    = 2'b11   // Following beat of a burst
	} htrans_t;

	// Address phase, driven by the master
	typedef struct packed {
		logic [w_addr-1:0] haddr;      // Byte address
		logic              hwrite;     // 1 for write
		htrans_t           htrans;     // Transfer type
		logic [2:0]        hsize;      // log2 of bytes per beat
		logic [2:0]        hburst;     // Carried, not decoded
		logic [3:0]        hprot;      // Carried, not decoded
		logic              hmastlock;  // Carried, not decoded
	} ahb_req_t;

	// Data phase response from a slave
	typedef struct packed {
		logic              hready_resp;  // Low inserts a wait state
		logic              hresp;        // High signals an error
		logic [w_data-1:0] hrdata;       // Read data
	} ahb_resp_t;

endpackage

//--- source/sram_sync.sv
module sram_sync #(
	parameter int depth = 2048
) (
	input  logic                               clk,
	input  logic [ahb_sram_pkg::w_bytes-1:0]   wen,
	input  logic [$clog2(depth)-1:0]           addr,
	input  logic [ahb_sram_pkg::w_data-1:0]    wdata,
	output logic [ahb_sram_pkg::w_data-1:0]    rdata
);

	import ahb_sram_pkg::*;

	// Word array, each word split into byte lanes
	logic [w_bytes-1:0][7:0] mem [depth];

	// Byte-lane writes, a lane is written only when its enable is set
	always_ff @(posedge clk) begin
		for (int i = 0; i < w_bytes; i++) begin
			if (wen[i]) begin
				mem[addr][i] <= wdata[8*i +: 8];  // One lane per enable bit
			end
		end
	end

	// Read port registered on every clock, old contents on a write to same word
	always_ff @(posedge clk) begin
		rdata <= mem[addr];
	end

endmodule

//--- source/ahb_sync_sram.sv
module ahb_sync_sram #(
	parameter int depth = 2048
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  ahb_sram_pkg::ahb_req_t          req,
	input  logic [ahb_sram_pkg::w_data-1:0] hwdata,
	output ahb_sram_pkg::ahb_resp_t         resp
);

	import ahb_sram_pkg::*;

	logic                     ready_q;       // Own ready, low for one cycle per write
	logic [w_bytes-1:0]       wen;           // Registered byte enables
	logic [w_bytes-1:0]       mask_size;     // Lanes covered by hsize, from lane 0
	logic [w_bytes-1:0]       mask;          // Lanes covered by the transfer
	logic [$clog2(depth)-1:0] addr_saved;    // Word address of the pending write
	logic [$clog2(depth)-1:0] sram_addr;     // Address presented to the RAM
	logic [w_data-1:0]        rdata;         // RAM read data
	logic                     write_accept;  // Write address phase taken here

	// 1, 2 or 4 low lanes set, then moved to the addressed lane
	assign mask_size = ~({w_bytes{1'b1}} << (1 << req.hsize));
	assign mask      = mask_size << req.haddr[$clog2(w_bytes)-1:0];

	// Splitter already gates htrans with bus ready, only own ready checked here
	assign write_accept = req.hwrite && ready_q &&
		(req.htrans == trans_nonseq || req.htrans == trans_seq);

	// Live address when ready, write address while waiting for hwdata
	assign sram_addr = ready_q ?
		req.haddr[$clog2(w_bytes) +: $clog2(depth)] : addr_saved;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_q <= 1'b1;
			wen     <= '0;
		end else if (write_accept) begin
			ready_q <= 1'b0;  // Wait state, hwdata arrives in this cycle
			wen     <= mask;  // RAM written at the edge ending the wait
		end else begin
			ready_q <= 1'b1;
			wen     <= '0;
		end
	end

	// Word address of the write, only read during the wait cycle
	always_ff @(posedge clk) begin
		if (write_accept) begin
			addr_saved <= req.haddr[$clog2(w_bytes) +: $clog2(depth)];
		end
	end

	sram_sync #(
		.depth (depth)
	) i_ram (
		.clk   (clk),
		.wen   (wen),
		.addr  (sram_addr),
		.wdata (hwdata),
		.rdata (rdata)
	);

	// Never signals an error
	assign resp = '{
		hready_resp: ready_q,
		hresp:       1'b0,
		hrdata:      rdata
	};

endmodule

//--- source/ahb_splitter.sv
module ahb_splitter (
	input  logic                    clk,
	input  logic                    rst_n,
	input  ahb_sram_pkg::ahb_req_t  req,
	input  logic                    hready,
	output ahb_sram_pkg::ahb_resp_t resp,
	output ahb_sram_pkg::ahb_req_t  req0,
	output ahb_sram_pkg::ahb_req_t  req1,
	input  ahb_sram_pkg::ahb_resp_t resp0,
	input  ahb_sram_pkg::ahb_resp_t resp1
);

	import ahb_sram_pkg::*;

	// Slave owning the current data phase
	typedef enum logic [1:0] {
		tgt_none,  // Idle or busy, answered here with okay
		tgt_mem0,
		tgt_mem1,
		tgt_err    // Unmapped, answered by the default slave
	} target_t;

	// Default slave progress through the two-cycle error
	typedef enum logic [1:0] {
		err_none,   // No error in the data phase
		err_wait,   // First cycle, ready low
		err_done    // Second cycle, ready high
	} err_state_t;

	logic       hit0;        // Address in SRAM 0 region
	logic       hit1;        // Address in SRAM 1 region
	logic       active;      // nonseq or seq
	logic       accept;      // Address phase taken this cycle
	target_t    target_q;
	err_state_t err_state;

	assign hit0   = (req.haddr & region_mask) == base0;
	assign hit1   = (req.haddr & region_mask) == base1;
	assign active = req.htrans == trans_nonseq || req.htrans == trans_seq;
	assign accept = hready && active;

	// Only the addressed slave sees the transfer, the other sees idle
	always_comb begin
		req0 = req;
		req1 = req;
		if (!(hready && hit0)) begin
			req0.htrans = trans_idle;
		end
		if (!(hready && hit1)) begin
			req1.htrans = trans_idle;
		end
	end

	// Target latched at the end of every address phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			target_q <= tgt_none;
		end else if (hready) begin
			if (!active)
				target_q <= tgt_none;
			else if (hit0)
				target_q <= tgt_mem0;
			else if (hit1)
				target_q <= tgt_mem1;
			else
				target_q <= tgt_err;
		end
	end

	// Default slave FSM
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			err_state <= err_none;
		end else if (accept && !hit0 && !hit1) begin
			err_state <= err_wait;  // Back-to-back errors restart from done
		end else if (err_state == err_wait) begin
			err_state <= err_done;
		end else begin
			err_state <= err_none;
		end
	end

	// Data-phase response mux
	always_comb begin
		case (target_q)
			tgt_mem0: resp = resp0;
			tgt_mem1: resp = resp1;
			tgt_err: begin
				resp.hready_resp = err_state != err_wait;
				resp.hresp       = err_state != err_none;
				resp.hrdata      = '0;
			end
			default: begin
				resp.hready_resp = 1'b1;  // Nothing in flight
				resp.hresp       = 1'b0;
				resp.hrdata      = '0;
			end
		endcase
	end

endmodule

//--- source/ahb_sram_subsys.sv
module ahb_sram_subsys (
	input  logic                            clk,
	input  logic                            rst_n,
	input  ahb_sram_pkg::ahb_req_t          req,
	input  logic                            hready,
	input  logic [ahb_sram_pkg::w_data-1:0] hwdata,
	output ahb_sram_pkg::ahb_resp_t         resp
);

	import ahb_sram_pkg::*;

	ahb_req_t  req0;   // To SRAM 0 slave
	ahb_req_t  req1;   // To SRAM 1 slave
	ahb_resp_t resp0;  // From SRAM 0 slave
	ahb_resp_t resp1;  // From SRAM 1 slave

	// Decoder, default slave and response mux
	ahb_splitter i_splitter (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (req),
		.hready (hready),
		.resp   (resp),
		.req0   (req0),
		.req1   (req1),
		.resp0  (resp0),
		.resp1  (resp1)
	);

	// 8 KiB at base0
	ahb_sync_sram #(
		.depth (depth0)
	) i_sram0 (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (req0),
		.hwdata (hwdata),  // Write data goes to both, only the selected one writes
		.resp   (resp0)
	);

	// 2 KiB at base1
	ahb_sync_sram #(
		.depth (depth1)
	) i_sram1 (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (req1),
		.hwdata (hwdata),
		.resp   (resp1)
	);

endmodule

//--- tb/ahb_sram_properties.sv
module ahb_sram_properties (
	input logic                    clk,
	input logic                    rst_n,
	input ahb_sram_pkg::ahb_req_t  req,
	input logic                    hready,
	input ahb_sram_pkg::ahb_resp_t resp
);

	import ahb_sram_pkg::*;

	int unsigned violations = 0;  // Failed assertions so far
	logic        write_dphase;    // Data phase belongs to a write

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			write_dphase <= 1'b0;
		else if (hready)
			write_dphase <= req.hwrite && (req.htrans == trans_nonseq || req.htrans == trans_seq);
	end

	// First error cycle is followed by the second
	err_second_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		!resp.hready_resp && resp.hresp |=> resp.hready_resp && resp.hresp)
		else begin violations++; $error("Error response lacks its second cycle"); end

	// Ready with error only right after the first error cycle
	err_only_in_sequence: assert property (@(posedge clk) disable iff (!rst_n)
		resp.hready_resp && resp.hresp |-> $past(!resp.hready_resp && resp.hresp))
		else begin violations++; $error("Error with ready outside an error response"); end

	// Exactly one wait state on a write
	write_single_wait: assert property (@(posedge clk) disable iff (!rst_n)
		write_dphase && !resp.hready_resp |=> resp.hready_resp)
		else begin violations++; $error("Write held ready low for two cycles"); end

	reset_ready: assert property (@(posedge clk) $rose(rst_n) |-> resp.hready_resp)
		else begin violations++; $error("Ready low in the first cycle after reset"); end

endmodule

bind ahb_sram_subsys ahb_sram_properties i_props (
	.clk    (clk),
	.rst_n  (rst_n),
	.req    (req),
	.hready (hready),
	.resp   (resp)
);

//--- tb/tb_ahb_sram_subsys.sv
module tb_ahb_sram_subsys;

	import ahb_sram_pkg::*;

	logic              clk;
	logic              rst_n;
	ahb_req_t          req;
	logic              hready;
	logic [w_data-1:0] hwdata;
	ahb_resp_t         resp;

	// Transfer now in its data phase
	logic              dp_write;
	logic              dp_read;
	logic              dp_err;     // Unmapped, error response expected
	logic [w_data-1:0] dp_wdata;
	logic [w_data-1:0] dp_rdata;   // Expected read data
	int                dp_line;    // Trace line of the transfer
	logic [15:0]       lfsr;       // Idle gap generator

	ahb_sram_subsys i_dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (req),
		.hready (hready),
		.hwdata (hwdata),
		.resp   (resp)
	);

	assign hready = resp.hready_resp;  // One slave, bus ready is its ready

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Galois form, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hb400;
		return state >> 1;
	endfunction

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_rdata(input logic [w_data-1:0] got, input logic [w_data-1:0] exp);
		if (got !== exp) begin
			$display("Fail hrdata at trace line %0d: got %h, expected %h", dp_line, got, exp);
			abort_run();
		end
	endtask

	task automatic check_hresp(input ahb_resp_t got, input logic exp);
		if (got.hresp !== exp) begin
			$display("Fail hresp at trace line %0d: got %h, expected %h", dp_line, got.hresp, exp);
			abort_run();
		end
	endtask

	task automatic check_waits(input int got, input int exp);
		if (got != exp) begin
			$display("Fail wait states at trace line %0d: got %h, expected %h", dp_line, got, exp);
			abort_run();
		end
	endtask

	// One address phase, overlapping the data phase of the previous transfer
	task automatic drive_phase(input ahb_req_t next, input logic [w_data-1:0] wdata,
		input logic [w_data-1:0] rdata, input logic err, input int line_no);
		int waits;
		waits = 0;
		@(negedge clk);
		req    = next;
		hwdata = dp_write ? dp_wdata : '0;  // Data of the transfer in data phase
		while (!resp.hready_resp) begin
			if (waits == 20) begin
				$display("Slave never became ready, trace line %0d", dp_line);
				abort_run();
			end
			waits++;
			@(negedge clk);
		end
		// Data phase ends at the next rising edge, response stable until then
		check_waits(waits, (dp_write || dp_err) ? 1 : 0);  // Writes and errors wait once
		check_hresp(resp, dp_err);
		if (dp_read && !dp_err)
			check_rdata(resp.hrdata, dp_rdata);
		dp_write = next.htrans == trans_nonseq && next.hwrite;
		dp_read  = next.htrans == trans_nonseq && !next.hwrite;
		dp_err   = err;
		dp_wdata = wdata;
		dp_rdata = rdata;
		dp_line  = line_no;
	endtask

	// Bound checker failures end the run
	always @(negedge clk) begin
		if (i_dut.i_props.violations != 0) begin
			$display("A protocol assertion in the bound checker failed");
			abort_run();
		end
	end

	initial begin : stimulus
		int                fd;
		int                n;
		int                line_no;
		string             line;
		string             op;
		logic [w_addr-1:0] addr;
		logic [2:0]        size;
		logic [w_data-1:0] wdata;
		logic [w_data-1:0] rdata;
		logic              err;
		logic [1:0]        gap;
		ahb_req_t          next_req;
		ahb_req_t          idle_req;

		rst_n    = 1'b0;
		req      = '0;  // htrans idle
		hwdata   = '0;
		dp_write = 1'b0;
		dp_read  = 1'b0;
		dp_err   = 1'b0;
		dp_wdata = '0;
		dp_rdata = '0;
		dp_line  = 0;
		lfsr     = 16'd93;
		idle_req = '0;
		line_no  = 0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		fd = $fopen("tb/ahb_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file tb/ahb_trace.txt");
			abort_run();
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			line_no++;
			if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#")
				continue;  // Blank or column notes
			n = $sscanf(line, "%s %h %h %h %h %h", op, addr, size, wdata, rdata, err);
			if (n != 6) begin
				$display("Trace line %0d does not hold six columns", line_no);
				abort_run();
			end
			next_req       = '0;
			next_req.haddr = addr;
			next_req.hsize = size;
			next_req.hprot = 4'b0011;  // Carried only
			if (op == "write") begin
				next_req.htrans = trans_nonseq;
				next_req.hwrite = 1'b1;
			end else if (op == "read") begin
				next_req.htrans = trans_nonseq;
			end else if (op != "idle") begin
				$display("Unknown operation %s on trace line %0d", op, line_no);
				abort_run();
			end
			drive_phase(next_req, wdata, rdata, err, line_no);
			// A write keeps its follower back to back
			if (op != "write") begin
				for (int b = 0; b < 2; b++) begin
					gap[b] = lfsr[0];
					lfsr   = lfsr_step(lfsr);
				end
				repeat (gap) drive_phase(idle_req, '0, '0, 1'b0, line_no);
			end
		end
		$fclose(fd);
		drive_phase(idle_req, '0, '0, 1'b0, line_no);  // Drains the last data phase

		if (i_dut.i_props.violations != 0) begin
			$display("A protocol assertion in the bound checker failed");
			abort_run();
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

//--- tb/ahb_trace.txt
# op addr(hex) hsize(hex) hwdata(hex) expected_hrdata(hex) expected_error(hex)
# hwdata carries the data on its byte lanes, hrdata is compared on good reads only
idle  00000000 0 00000000 00000000 0
write 00000000 2 11223344 00000000 0
write 00000004 2 a5a5a5a5 00000000 0
write 00010000 2 cafef00d 00000000 0
idle  00000000 0 00000000 00000000 0
read  00000000 2 00000000 11223344 0
read  00000004 2 00000000 a5a5a5a5 0
read  00010000 2 00000000 cafef00d 0
write 00000020 2 00000000 00000000 0
write 00000020 0 deadbe11 00000000 0
write 00000021 0 dead22ef 00000000 0
write 00000022 0 de33beef 00000000 0
write 00000023 0 44adbeef 00000000 0
read  00000020 2 00000000 44332211 0
write 00000024 2 ffffffff 00000000 0
write 00000024 1 1234abcd 00000000 0
read  00000024 2 00000000 ffffabcd 0
write 00000026 1 5678aaaa 00000000 0
read  00000024 2 00000000 5678abcd 0
write 00010004 2 00000000 00000000 0
write 00010005 0 0000ee00 00000000 0
write 00010006 1 7777ffff 00000000 0
read  00010004 2 00000000 7777ee00 0
write 00000008 2 13572468 00000000 0
read  00000008 2 00000000 13572468 0
write 00000008 2 9abcdef0 00000000 0
read  00000008 2 00000000 9abcdef0 0
write 00020000 2 deadbeef 00000000 1
write 80000004 2 deadbeef 00000000 1
read  ffff0000 2 00000000 00000000 1
write 00030000 2 0badf00d 00000000 1
read  00000000 2 00000000 11223344 0
read  00000004 2 00000000 a5a5a5a5 0
read  00010000 2 00000000 cafef00d 0
write 00000100 2 00000a00 00000000 0
write 00010100 2 00000b11 00000000 0
read  00000100 2 00000000 00000a00 0
read  00010100 2 00000000 00000b11 0
write 00001ffc 2 7f7f0001 00000000 0
write 000107fc 2 7f7f0002 00000000 0
idle  00000000 0 00000000 00000000 0
read  00001ffc 2 00000000 7f7f0001 0
read  000107fc 2 00000000 7f7f0002 0

//--- vlog.f
source/ahb_sram_pkg.sv
source/sram_sync.sv
source/ahb_sync_sram.sv
source/ahb_splitter.sv
source/ahb_sram_subsys.sv
tb/ahb_sram_properties.sv
tb/tb_ahb_sram_subsys.sv

//--- Bender.yml
package:
  name: ahb_sram_subsys

sources:
  - files:
      - source/ahb_sram_pkg.sv
      - source/sram_sync.sv
      - source/ahb_sync_sram.sv
      - source/ahb_splitter.sv
      - source/ahb_sram_subsys.sv
  - target: test
    files:
      - tb/ahb_sram_properties.sv
      - tb/tb_ahb_sram_subsys.sv
